/* files.f */
hdl/mix_cfg_pkg.sv
hdl/mix_audio_pkg.sv
hdl/mix_apb_regs.sv
hdl/mix_settle.sv
hdl/mix_source_decode.sv
hdl/mix_sum_clamp.sv
hdl/mix_compress.sv
hdl/mix_top.sv
bench/mix_tb.sv

/* Bender.yml */
package:
  name: mix_audio

sources:
  - files:
      - hdl/mix_cfg_pkg.sv
      - hdl/mix_audio_pkg.sv
      - hdl/mix_apb_regs.sv
      - hdl/mix_settle.sv
      - hdl/mix_source_decode.sv
      - hdl/mix_sum_clamp.sv
      - hdl/mix_compress.sv
      - hdl/mix_top.sv
  - target: test
    files:
      - bench/mix_tb.sv

/* bench/mix_tb.sv */
//////////////////////////////////////////////////
// Checks audio_out 10 cycles after the inputs settle;
// all stimulus moves 1 ns after the rising edge
//////////////////////////////////////////////////
`timescale 1ns/1ps

module mix_tb;

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int MIX_IDX        = 0;
	localparam int SAT_IDX        = 1;
	localparam int BOOST_IDX      = 2;
	localparam int SETTLE_IDX     = 3;

	logic                         clk_chipset;
	logic                         reset;
	mix_cfg_pkg::apb_req_t        apb_req;
	mix_cfg_pkg::apb_rsp_t        apb_rsp;
	mix_audio_pkg::opl_sample_t   opl_in;
	mix_audio_pkg::tandy_raw_t    tandy_in;
	logic                         speaker_in;
	mix_audio_pkg::audio_sample_t audio_out;
	logic [1:0]                   mix_mode;

	mix_audio_pkg::audio_sample_t expected;
	mix_cfg_pkg::mix_cfg_t        cur_cfg;
	logic [3:0]                   check_en;
	string                        test_name;
	int                           errors;
	int                           errors_at_start;
	int                           tests_run;
	int                           tests_failed;
	int                           cycles;
	int                           knee_values[4];

	mix_top dut_i (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.opl_in      (opl_in),
		.tandy_in    (tandy_in),
		.speaker_in  (speaker_in),
		.audio_out   (audio_out),
		.mix_mode    (mix_mode)
	);

	initial begin
		clk_chipset = 1'b0;
		forever #4 clk_chipset = ~clk_chipset;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Scaled sum kept at 17 bits, then saturated to 16
	function automatic mix_audio_pkg::audio_sample_t mix_model(
		input int                    opl,
		input int                    tandy,
		input logic                  spk_off,
		input mix_cfg_pkg::mix_cfg_t c
	);
		int          sum;
		logic [16:0] kept;
		sum = opl + ((tandy << c.tandy_vol) << mix_audio_pkg::TANDY_SHIFT);
		if (!spk_off)
			sum = sum + ((1 << c.speaker_vol) << mix_audio_pkg::SPEAKER_SHIFT);
		kept = sum[16:0];
		if (kept[16] != kept[15])
			return kept[16] ? 16'h8000 : 16'h7FFF;
		return kept[15:0];
	endfunction

	// Curve on the magnitude, limited to full scale, sign restored
	function automatic mix_audio_pkg::audio_sample_t boost_model(
		input mix_audio_pkg::audio_sample_t x,
		input logic [1:0]                   boost
	);
		int mag;
		int knee;
		int base;
		int fall;
		int gain;
		int val;
		if (boost == 2'd0)
			return x;
		mag = (x < 0) ? -int'(x) : int'(x);
		if (boost == 2'd1) begin
			knee = int'(mix_audio_pkg::COMP_X1);
			base = int'(mix_audio_pkg::COMP_B1);
			fall = int'(mix_audio_pkg::COMP_F1);
			gain = int'(mix_audio_pkg::COMP_A1);
		end else begin
			knee = int'(mix_audio_pkg::COMP_X2);
			base = int'(mix_audio_pkg::COMP_B2);
			fall = int'(mix_audio_pkg::COMP_F2);
			gain = int'(mix_audio_pkg::COMP_A2);
		end
		val = (mag < knee) ? mag * gain : (mag - knee) / fall + base;
		if (val > 32767)
			val = 32767;
		return (x < 0) ? 16'(-val) : 16'(val);
	endfunction

	//////////////////////////////////////////////////
	// Checks and reporting
	//////////////////////////////////////////////////

	property out_matches(en);
		@(posedge clk_chipset) disable iff (reset)
		en |-> (audio_out == expected);
	endproperty

	task automatic report_mismatch(input logic [15:0] exp, input logic [15:0] act);
		errors++;
		$display("Fail %s: expected %h, actual %h", test_name, exp, act);
	endtask

	mix_ok: assert property (out_matches(check_en[MIX_IDX]))
		else report_mismatch($sampled(expected), $sampled(audio_out));
	sat_ok: assert property (out_matches(check_en[SAT_IDX]))
		else report_mismatch($sampled(expected), $sampled(audio_out));
	boost_ok: assert property (out_matches(check_en[BOOST_IDX]))
		else report_mismatch($sampled(expected), $sampled(audio_out));
	settle_ok: assert property (out_matches(check_en[SETTLE_IDX]))
		else report_mismatch($sampled(expected), $sampled(audio_out));

	task automatic check_value(input string what, input int exp, input int act);
		assert (exp == act)
			else begin
				errors++;
				$display("Fail %s (%s): expected %0h, actual %0h", test_name, what, exp, act);
			end
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == errors_at_start) begin
			$display("Test %s: passed", test_name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	//////////////////////////////////////////////////
	// Bus and stimulus tasks
	//////////////////////////////////////////////////

	// Setup cycle, then access cycle where the response is valid
	task automatic bus_transfer(input logic [7:0] addr, input logic write,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge clk_chipset);
		#1;
		apb_req.penable = 1'b1;
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge clk_chipset);
		#1;
		apb_req = '0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		bus_transfer(addr, 1'b1, data, unused, err);
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data, output logic err);
		bus_transfer(addr, 1'b0, 32'd0, data, err);
	endtask

	task automatic set_cfg(input logic [1:0] svol, input logic [1:0] tvol,
		input logic [1:0] boost, input logic [1:0] stereo);
		logic err;
		cur_cfg.speaker_vol = svol;
		cur_cfg.tandy_vol   = tvol;
		cur_cfg.boost       = boost;
		cur_cfg.stereo_mix  = stereo;
		write_reg(mix_cfg_pkg::ADDR_CTRL, {24'b0, cur_cfg}, err);
		check_value("ctrl write error", 0, int'(err));
	endtask

	// Drive one sample set, let it settle, then check for two cycles
	task automatic run_vector(input mix_audio_pkg::opl_sample_t opl,
		input mix_audio_pkg::tandy_raw_t tandy, input logic spk_off, input int which);
		check_en   = '0;
		opl_in     = opl;
		tandy_in   = tandy;
		speaker_in = spk_off;
		expected   = boost_model(mix_model(int'(opl), int'(tandy), spk_off, cur_cfg),
			cur_cfg.boost);
		repeat (10) @(posedge clk_chipset);
		#1;
		check_en[which] = 1'b1;
		repeat (2) @(posedge clk_chipset);
		#1;
		check_en = '0;
	endtask

	// Run limit
	always @(posedge clk_chipset) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [31:0]                rdata;
		logic [31:0]                rnd;
		logic                       err;
		mix_audio_pkg::opl_sample_t opl_val;
		void'($urandom(94));
		reset      = 1'b1;
		apb_req    = '0;
		opl_in     = '0;
		tandy_in   = '0;
		speaker_in = 1'b1;
		check_en   = '0;
		expected   = '0;
		cur_cfg    = '0;
		errors     = 0;
		tests_run  = 0;
		tests_failed = 0;
		cycles     = 0;
		knee_values[0] = int'(mix_audio_pkg::COMP_X2) - 1;
		knee_values[1] = int'(mix_audio_pkg::COMP_X2);
		knee_values[2] = int'(mix_audio_pkg::COMP_X1) - 1;
		knee_values[3] = int'(mix_audio_pkg::COMP_X1);
		repeat (3) @(posedge clk_chipset);
		#1;
		reset = 1'b0;

		start_test("reset");
		check_value("audio_out", 0, int'(audio_out));
		check_value("mix_mode", 0, int'(mix_mode));
		read_reg(mix_cfg_pkg::ADDR_CTRL, rdata, err);
		check_value("ctrl read", 0, int'(rdata));
		check_value("pslverr", 0, int'(err));
		end_test();

		start_test("config");
		set_cfg(2'd1, 2'd2, 2'd0, 2'd3);
		read_reg(mix_cfg_pkg::ADDR_CTRL, rdata, err);
		check_value("ctrl read", int'(cur_cfg), int'(rdata));
		check_value("mix_mode", 3, int'(mix_mode));
		set_cfg(2'd3, 2'd0, 2'd2, 2'd1);
		read_reg(mix_cfg_pkg::ADDR_CTRL, rdata, err);
		check_value("ctrl read", int'(cur_cfg), int'(rdata));
		check_value("mix_mode", 1, int'(mix_mode));
		write_reg(8'h08, 32'hFF, err);
		check_value("unmapped write pslverr", 1, int'(err));
		read_reg(8'h08, rdata, err);
		check_value("unmapped read pslverr", 1, int'(err));
		read_reg(mix_cfg_pkg::ADDR_CTRL, rdata, err);
		check_value("ctrl after unmapped", int'(cur_cfg), int'(rdata));
		end_test();

		start_test("mixing");
		for (int i = 0; i < 20; i++) begin
			rnd = $urandom;
			set_cfg(rnd[1:0], rnd[3:2], 2'd0, rnd[5:4]);
			rnd = $urandom;
			run_vector(rnd[15:0], rnd[23:16], rnd[24], MIX_IDX);
		end
		end_test();

		start_test("saturation");
		set_cfg(2'd0, 2'd3, 2'd0, 2'd0);
		write_reg(mix_cfg_pkg::ADDR_STATUS, 32'd0, err);
		run_vector(16'sd30000, 8'h40, 1'b0, SAT_IDX);
		read_reg(mix_cfg_pkg::ADDR_STATUS, rdata, err);
		check_value("clip flag set", 1, int'(rdata[0]));
		// Quiet input first, or the flag would set again right away
		run_vector(16'sd0, 8'h00, 1'b1, SAT_IDX);
		write_reg(mix_cfg_pkg::ADDR_STATUS, 32'd0, err);
		read_reg(mix_cfg_pkg::ADDR_STATUS, rdata, err);
		check_value("clip flag cleared", 0, int'(rdata[0]));
		run_vector(16'sh8000, 8'h00, 1'b1, SAT_IDX);
		end_test();

		start_test("boost");
		for (int b = 1; b <= 3; b++) begin
			set_cfg(2'd0, 2'd0, b[1:0], 2'd0);
			for (int i = 0; i < 8; i++) begin
				rnd = $urandom;
				if (i < 4) begin
					opl_val = 16'(knee_values[i]);
					if (rnd[16])
						opl_val = -opl_val;
				end else begin
					opl_val = rnd[15:0];
				end
				run_vector(opl_val, 8'h00, 1'b1, BOOST_IDX);
			end
		end
		end_test();

		start_test("settle");
		set_cfg(2'd0, 2'd0, 2'd0, 2'd0);
		run_vector(16'sd1000, 8'h00, 1'b1, SETTLE_IDX);
		check_en[SETTLE_IDX] = 1'b1;
		// One-cycle glitch on the FM input
		opl_in = -16'sd12000;
		@(posedge clk_chipset);
		#1;
		opl_in = 16'sd1000;
		repeat (12) @(posedge clk_chipset);
		#1;
		check_en = '0;
		end_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* hdl/mix_top.sv */
//////////////////////////////////////////////////
// Sample inputs to audio_out take 7 cycles, speaker
// and volume changes 4; no back-pressure anywhere
//////////////////////////////////////////////////
`timescale 1ns/1ps

module mix_top (
	input  logic                         clk_chipset,
	input  logic                         reset,
	input  mix_cfg_pkg::apb_req_t        apb_req,
	output mix_cfg_pkg::apb_rsp_t        apb_rsp,
	input  mix_audio_pkg::opl_sample_t   opl_in,
	input  mix_audio_pkg::tandy_raw_t    tandy_in,
	input  logic                         speaker_in,
	output mix_audio_pkg::audio_sample_t audio_out,
	output logic [1:0]                   mix_mode
);

	mix_cfg_pkg::mix_cfg_t        cfg;
	mix_audio_pkg::mix_sources_t  sources;
	mix_audio_pkg::audio_sample_t clamped;
	logic                         clip_pulse;

	// Stereo mix code goes straight out to the board
	assign mix_mode = cfg.stereo_mix;

	//////////////////////////////////////////////////
	// Configuration
	//////////////////////////////////////////////////

	mix_apb_regs regs_i (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.clip_pulse  (clip_pulse),
		.cfg         (cfg)
	);

	//////////////////////////////////////////////////
	// Audio pipeline
	//////////////////////////////////////////////////

	// Decode
	mix_source_decode decode_i (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.opl_in      (opl_in),
		.tandy_in    (tandy_in),
		.speaker_in  (speaker_in),
		.cfg         (cfg),
		.sources     (sources)
	);

	// Execute
	mix_sum_clamp sum_clamp_i (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.sources     (sources),
		.sample      (clamped),
		.clip_pulse  (clip_pulse)
	);

	// Result
	mix_compress compress_i (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.sample      (clamped),
		.cfg         (cfg),
		.audio_out   (audio_out)
	);

endmodule

/* hdl/mix_compress.sv */
//////////////////////////////////////////////////
// Boost works on the magnitude; curve results above
// full scale are limited to 0x7FFF before the sign returns
//////////////////////////////////////////////////
`timescale 1ns/1ps

module mix_compress (
	input  logic                         clk_chipset,
	input  logic                         reset,
	input  mix_audio_pkg::audio_sample_t sample,
	input  mix_cfg_pkg::mix_cfg_t        cfg,
	output mix_audio_pkg::audio_sample_t audio_out
);

	logic                         neg;
	logic [16:0]                  mag;
	logic [16:0]                  mag_2x;
	logic [16:0]                  mag_4x;
	logic [16:0]                  mag_boost;
	logic [15:0]                  mag_limited;
	mix_audio_pkg::audio_sample_t boosted;

	// Steep slope up to the knee, then a flat one
	function automatic logic [16:0] boost_curve(
		input logic [16:0] m,
		input logic [16:0] knee,
		input logic [16:0] base,
		input logic [16:0] fall,
		input logic [16:0] gain
	);
		logic [16:0] val;
		if (m < knee)
			val = m * gain;
		else
			val = ((m - knee) / fall) + base;
		return val;
	endfunction

	always_comb begin
		neg = sample[15];

		// 0x8000 gives a magnitude of 32768, hence 17 bits
		mag = neg ? (~{sample[15], sample}) + 17'd1 : {1'b0, sample};

		mag_2x = boost_curve(mag, mix_audio_pkg::COMP_X1, mix_audio_pkg::COMP_B1,
			mix_audio_pkg::COMP_F1, mix_audio_pkg::COMP_A1);
		mag_4x = boost_curve(mag, mix_audio_pkg::COMP_X2, mix_audio_pkg::COMP_B2,
			mix_audio_pkg::COMP_F2, mix_audio_pkg::COMP_A2);

		// Boost 2 and 3 both select the 4x curve
		mag_boost = (cfg.boost == 2'd1) ? mag_2x : mag_4x;

		// Both curves end a little above full scale
		if (mag_boost > 17'h07FFF)
			mag_limited = 16'h7FFF;
		else
			mag_limited = mag_boost[15:0];

		boosted = neg ? -mag_limited : mag_limited;
	end

	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset)
			audio_out <= '0;
		else if (cfg.boost == 2'd0)
			audio_out <= sample;
		else
			audio_out <= boosted;
	end

	// Compression never flips the polarity of a sample
	sign_kept: assert property (
		@(posedge clk_chipset) disable iff (reset)
		(audio_out != '0) |-> (audio_out[15] == $past(sample[15]))
	);

endmodule

/* hdl/mix_sum_clamp.sv */
//////////////////////////////////////////////////
// Two cycles: sum register, then clamp register
//////////////////////////////////////////////////
`timescale 1ns/1ps

module mix_sum_clamp (
	input  logic                        clk_chipset,
	input  logic                        reset,
	input  mix_audio_pkg::mix_sources_t sources,
	output mix_audio_pkg::audio_sample_t sample,
	output logic                        clip_pulse
);

	mix_audio_pkg::mix_word_t sum_q;

	// Sum wraps at 17 bits before the clamp sees it
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset)
			sum_q <= '0;
		else
			sum_q <= sources.opl + sources.tandy + sources.speaker;
	end

	// Top two bits differ when the sum is outside 16-bit range
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			sample     <= '0;
			clip_pulse <= 1'b0;
		end else if (sum_q[16] != sum_q[15]) begin
			sample     <= {sum_q[16], {15{~sum_q[16]}}};
			clip_pulse <= 1'b1;
		end else begin
			sample     <= sum_q[15:0];
			clip_pulse <= 1'b0;
		end
	end

	// Every clip lands on one of the two full scale limits
	clip_at_limit: assert property (
		@(posedge clk_chipset) disable iff (reset)
		clip_pulse |-> ((sample == 16'h7FFF) || (sample == 16'h8000))
	);

endmodule

/* hdl/mix_source_decode.sv */
//////////////////////////////////////////////////
// Tandy and speaker are never negative; speaker_in
// high means the speaker is off
//////////////////////////////////////////////////
`timescale 1ns/1ps

module mix_source_decode (
	input  logic                        clk_chipset,
	input  logic                        reset,
	input  mix_audio_pkg::opl_sample_t  opl_in,
	input  mix_audio_pkg::tandy_raw_t   tandy_in,
	input  logic                        speaker_in,
	input  mix_cfg_pkg::mix_cfg_t       cfg,
	output mix_audio_pkg::mix_sources_t sources
);

	mix_audio_pkg::opl_sample_t  opl_settled;
	mix_audio_pkg::tandy_raw_t   tandy_settled;
	logic [10:0]                 tandy_scaled;
	logic [3:0]                  speaker_scaled;
	mix_audio_pkg::mix_sources_t sources_next;

	//////////////////////////////////////////////////
	// Settling of the sample inputs
	//////////////////////////////////////////////////

	mix_settle #(
		.payload_t (mix_audio_pkg::opl_sample_t)
	) opl_settle_i (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.din         (opl_in),
		.dout        (opl_settled)
	);

	mix_settle #(
		.payload_t (mix_audio_pkg::tandy_raw_t)
	) tandy_settle_i (
		.clk_chipset (clk_chipset),
		.reset       (reset),
		.din         (tandy_in),
		.dout        (tandy_settled)
	);

	//////////////////////////////////////////////////
	// Volume scaling into the mix width
	//////////////////////////////////////////////////

	always_comb begin
		// Volume shift first, then the fixed shift
		tandy_scaled   = {3'b000, tandy_settled} << cfg.tandy_vol;
		speaker_scaled = 4'b0001 << cfg.speaker_vol;

		sources_next.opl   = {opl_settled[15], opl_settled};
		sources_next.tandy = {6'b0, tandy_scaled} << mix_audio_pkg::TANDY_SHIFT;

		if (speaker_in)
			sources_next.speaker = '0;
		else
			sources_next.speaker = {13'b0, speaker_scaled} << mix_audio_pkg::SPEAKER_SHIFT;
	end

	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset)
			sources <= '0;
		else
			sources <= sources_next;
	end

endmodule

/* hdl/mix_settle.sv */
//////////////////////////////////////////////////
// Input change shows on dout 3 cycles later, and only
// if it held for at least 2 cycles
//////////////////////////////////////////////////
`timescale 1ns/1ps

module mix_settle #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk_chipset,
	input  logic     reset,
	input  payload_t din,
	output payload_t dout
);

	payload_t stage0;
	payload_t stage1;

	// Two sample stages, then a hold register that only moves
	// when both stages agree, so a glitching word is never passed
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			stage0 <= '0;
			stage1 <= '0;
			dout   <= '0;
		end else begin
			stage0 <= din;
			stage1 <= stage0;
			if (stage0 == stage1)
				dout <= stage1;
		end
	end

endmodule

/* hdl/mix_apb_regs.sv */
//////////////////////////////////////////////////
// Zero wait state APB slave; read data and pslverr
// are captured in the setup cycle
//////////////////////////////////////////////////
`timescale 1ns/1ps

module mix_apb_regs (
	input  logic                  clk_chipset,
	input  logic                  reset,
	input  mix_cfg_pkg::apb_req_t apb_req,
	output mix_cfg_pkg::apb_rsp_t apb_rsp,
	input  logic                  clip_pulse,
	output mix_cfg_pkg::mix_cfg_t cfg
);

	logic        setup_phase;
	logic        write_access;
	logic        addr_ctrl;
	logic        addr_status;
	logic        addr_ok;
	logic        clip_flag;
	logic [31:0] read_data;

	// Address decode
	assign addr_ctrl    = (apb_req.paddr == mix_cfg_pkg::ADDR_CTRL);
	assign addr_status  = (apb_req.paddr == mix_cfg_pkg::ADDR_STATUS);
	assign addr_ok      = addr_ctrl || addr_status;

	assign setup_phase  = apb_req.psel && !apb_req.penable;
	assign write_access = apb_req.psel && apb_req.penable && apb_req.pwrite;

	// Read mux
	always_comb begin
		read_data = '0;
		if (addr_ctrl)
			read_data = {24'b0, cfg};
		else if (addr_status)
			read_data[0] = clip_flag;
	end

	// Response is loaded at the end of setup and dropped after access
	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			apb_rsp <= '0;
		end else if (setup_phase) begin
			apb_rsp.prdata  <= apb_req.pwrite ? '0 : read_data;
			apb_rsp.pslverr <= !addr_ok;
		end else begin
			apb_rsp <= '0;
		end
	end

	//////////////////////////////////////////////////
	// Configuration and sticky clip flag
	//////////////////////////////////////////////////

	always_ff @(posedge clk_chipset, posedge reset) begin
		if (reset) begin
			cfg       <= mix_cfg_pkg::CFG_RESET;
			clip_flag <= 1'b0;
		end else begin
			if (write_access && addr_ctrl)
				cfg <= mix_cfg_pkg::mix_cfg_t'(apb_req.pwdata[7:0]);

			// Clear by software wins over a new clip in the same cycle
			if (write_access && addr_status)
				clip_flag <= 1'b0;
			else if (clip_pulse)
				clip_flag <= 1'b1;
		end
	end

	// Master must never start an access phase without a select
	penable_needs_psel: assert property (
		@(posedge clk_chipset) disable iff (reset)
		apb_req.penable |-> apb_req.psel
	);

endmodule

/* hdl/mix_audio_pkg.sv */
//////////////////////////////////////////////////
// Mix width is one bit wider than the output; a full
// volume sum of all three sources can still wrap
//////////////////////////////////////////////////
package mix_audio_pkg;

	// FM synth sample, two's complement
	typedef logic signed [15:0] opl_sample_t;

	// Tandy sound chip sample, unsigned
	typedef logic [7:0] tandy_raw_t;

	// Common mix width
	typedef logic signed [16:0] mix_word_t;

	// Final output sample
	typedef logic signed [15:0] audio_sample_t;

	// The three sources, already scaled to the mix width
	typedef struct packed {
		mix_word_t opl;
		mix_word_t tandy;
		mix_word_t speaker;
	} mix_sources_t;

	// Fixed left shifts after the volume shift
	localparam int unsigned TANDY_SHIFT   = 4;
	localparam int unsigned SPEAKER_SHIFT = 11;

	//////////////////////////////////////////////////
	// Boost curves
	// Below the knee X the magnitude is multiplied by A,
	// above it the slope drops to 1/F starting at B
	//////////////////////////////////////////////////

	// 2x curve
	localparam logic [16:0] COMP_X1 = 17'd14044;
	localparam logic [16:0] COMP_B1 = 17'd28088;
	localparam logic [16:0] COMP_F1 = 17'd4;
	localparam logic [16:0] COMP_A1 = 17'd2;

	// 4x curve
	localparam logic [16:0] COMP_X2 = 17'd7400;
	localparam logic [16:0] COMP_B2 = 17'd29600;
	localparam logic [16:0] COMP_F2 = 17'd8;
	localparam logic [16:0] COMP_A2 = 17'd4;

endpackage

/* hdl/mix_cfg_pkg.sv */
//////////////////////////////////////////////////
// Byte addresses, 8 bits wide; unmapped ones get pslverr
//////////////////////////////////////////////////
package mix_cfg_pkg;

	// Request from the bus master, one transfer at a time
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	// Response, valid in the access cycle
	typedef struct packed {
		logic [31:0] prdata;
		logic        pslverr;
	} apb_rsp_t;

	// Boost is 0 off, 1 the 2x curve, 2 and 3 the 4x curve
	typedef struct packed {
		logic [1:0] stereo_mix;
		logic [1:0] boost;
		logic [1:0] tandy_vol;
		logic [1:0] speaker_vol;
	} mix_cfg_t;

	// Register map
	localparam logic [7:0] ADDR_CTRL   = 8'h00;
	localparam logic [7:0] ADDR_STATUS = 8'h04;

	localparam mix_cfg_t CFG_RESET = '0;

endpackage
